// ==== src/sdram_pkg.sv ====
package sdram_pkg;

	////////////////////////////////////////
	// Host and device geometry
	////////////////////////////////////////

	localparam int ADDR_W = 22;  // 4M words
	localparam int DATA_W = 16;
	localparam int BANK_W = 2;   // 4 banks
	localparam int ROW_W  = 12;  // 4096 rows
	localparam int COL_W  = 8;   // 256 columns

	////////////////////////////////////////
	// Device timings in clocks
	////////////////////////////////////////

	localparam int T_RFC       = 3;  // Auto refresh, 66 ns rounded up
	localparam int T_RP        = 1;  // Precharge
	localparam int T_RCD       = 1;  // Activate to read or write
	localparam int T_MRD       = 2;  // Mode register load
	localparam int CAS_LATENCY = 2;

	// Single write burst, CL2, sequential, BL1
	localparam logic [ROW_W-1:0] MODE_REG = 12'b00_1_00_010_0_000;

	// Precharge-all on PRECHARGE, auto precharge on READ/WRITE
	localparam int A10_BIT = 10;

	// Commands as seen by the pin driver
	typedef enum logic [2:0]
	{
		CMD_NOP       = 3'd0,
		CMD_ACTIVE    = 3'd1,
		CMD_READ      = 3'd2,
		CMD_WRITE     = 3'd3,
		CMD_PRECHARGE = 3'd4,
		CMD_REFRESH   = 3'd5,
		CMD_LMR       = 3'd6
	} sdram_cmd_e;

	// Host address split by field, bank on top
	typedef struct packed
	{
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0]  row;
		logic [COL_W-1:0]  col;
	} host_addr_t;

	typedef struct packed
	{
		logic              write;  // High for write, low for read
		host_addr_t        addr;
		logic [DATA_W-1:0] wdata;  // Ignored on reads
	} host_req_t;

	// Device pins, command strobes active low
	typedef struct packed
	{
		logic              cke;
		logic              cs_n;
		logic              ras_n;
		logic              cas_n;
		logic              we_n;
		logic [BANK_W-1:0] ba;
		logic [ROW_W-1:0]  a;
	} sdram_pins_t;

endpackage

// ==== src/sdram_refresh_timer.sv ====
`timescale 1ns/1ps

module sdram_refresh_timer #(
	parameter int REFRESH_PERIOD = 490
) (
	input  logic clk,
	input  logic rst,
	input  logic init_done,
	input  logic refresh_issued,
	output logic refresh_pending
);

	localparam int CNT_W = $clog2(REFRESH_PERIOD + 1);

	logic [CNT_W-1:0] cnt;
	logic tick;

	assign tick = (cnt == CNT_W'(REFRESH_PERIOD - 1));  // One interval elapsed

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt             <= '0;
			refresh_pending <= 1'b0;
		end
		else
		begin
			if (!init_done)
				cnt <= '0;  // Held until device configured
			else if (tick)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			if (init_done && tick)
				refresh_pending <= 1'b1;  // New interval beats a clear
			else if (refresh_issued)
				refresh_pending <= 1'b0;
		end
	end

endmodule

// ==== src/sdram_req_latch.sv ====
`timescale 1ns/1ps

module sdram_req_latch (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 req,
	input  sdram_pkg::host_req_t host_req,
	input  logic                 set_open,
	input  logic                 clear_open,
	input  logic                 ack,
	output logic                 pending,
	output sdram_pkg::host_req_t req_q,
	output logic                 row_hit,
	output logic                 row_open
);

	logic [sdram_pkg::BANK_W-1:0] open_bank;  // Bank of last ACTIVE
	logic [sdram_pkg::ROW_W-1:0]  open_row;   // Row of last ACTIVE

	// Control flags
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pending  <= 1'b0;
			row_open <= 1'b0;
		end
		else
		begin
			if (req)
				pending <= 1'b1;  // New request wins over ack of the old one
			else if (ack)
				pending <= 1'b0;
			if (clear_open)
				row_open <= 1'b0;
			else if (set_open)
				row_open <= 1'b1;
		end
	end

	// Request and open row payload
	always_ff @(posedge clk)
	begin
		if (req)
			req_q <= host_req;
		if (set_open)
		begin
			open_bank <= req_q.addr.bank;  // ACTIVE always targets the latched request
			open_row  <= req_q.addr.row;
		end
	end

	assign row_hit = row_open && (open_bank == req_q.addr.bank) && (open_row == req_q.addr.row);

endmodule

// ==== src/sdram_pin_driver.sv ====
`timescale 1ns/1ps

module sdram_pin_driver (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          init_done,
	input  sdram_pkg::sdram_cmd_e         cmd,
	input  sdram_pkg::host_addr_t         cmd_addr,
	input  logic                          precharge_all,
	input  logic [sdram_pkg::DATA_W-1:0]  wdata,
	input  logic                          capture,
	output sdram_pkg::sdram_pins_t        pins,
	output logic [sdram_pkg::DATA_W-1:0]  dq_out,
	output logic                          dq_oe,
	input  logic [sdram_pkg::DATA_W-1:0]  dq_in,
	output logic [sdram_pkg::DATA_W-1:0]  rd_data
);

	logic cke_q, cs_n_q;
	logic [2:0] rcw_q, rcw_d;                     // ras_n, cas_n, we_n
	logic [sdram_pkg::BANK_W-1:0] ba_q, ba_d;
	logic [sdram_pkg::ROW_W-1:0]  a_q, a_d;

	////////////////////////////////////////
	// Command encode
	////////////////////////////////////////

	always_comb
	begin
		rcw_d = 3'b111;  // NOP
		ba_d  = '0;
		a_d   = '0;
		case (cmd)
			sdram_pkg::CMD_ACTIVE:
			begin
				rcw_d = 3'b011;
				ba_d  = cmd_addr.bank;
				a_d   = cmd_addr.row;
			end
			sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE:
			begin
				rcw_d = (cmd == sdram_pkg::CMD_WRITE) ? 3'b100 : 3'b101;
				ba_d  = cmd_addr.bank;
				a_d[sdram_pkg::COL_W-1:0] = cmd_addr.col;  // A10 low, row stays open
			end
			sdram_pkg::CMD_PRECHARGE:
			begin
				rcw_d = 3'b010;
				a_d[sdram_pkg::A10_BIT] = precharge_all;
			end
			sdram_pkg::CMD_REFRESH:
				rcw_d = 3'b001;
			sdram_pkg::CMD_LMR:
			begin
				rcw_d = 3'b000;
				a_d   = sdram_pkg::MODE_REG;
			end
			default:
				rcw_d = 3'b111;
		endcase
	end

	// Control pins, deselected in reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cke_q  <= 1'b0;
			cs_n_q <= 1'b1;
			rcw_q  <= 3'b111;
			dq_oe  <= 1'b0;
		end
		else
		begin
			cke_q  <= 1'b1;
			cs_n_q <= ~cke_q;  // Select one cycle after cke
			rcw_q  <= rcw_d;
			dq_oe  <= init_done && (cmd == sdram_pkg::CMD_WRITE);  // Bus released until configured
		end
	end

	// Address and data payload
	always_ff @(posedge clk)
	begin
		ba_q <= ba_d;
		a_q  <= a_d;
		if (cmd == sdram_pkg::CMD_WRITE)
			dq_out <= wdata;  // Valid alongside WRITE on the pins
		if (capture)
			rd_data <= dq_in;
	end

	assign pins = '{cke: cke_q, cs_n: cs_n_q, ras_n: rcw_q[2], cas_n: rcw_q[1],
		we_n: rcw_q[0], ba: ba_q, a: a_q};

endmodule

// ==== src/sdram_ctrl_fsm.sv ====
`timescale 1ns/1ps

module sdram_ctrl_fsm #(
	parameter int INIT_DELAY = 3200
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   pending,
	input  logic                   row_hit,
	input  logic                   row_open,
	input  sdram_pkg::host_req_t   req_q,
	input  logic                   refresh_pending,
	output sdram_pkg::sdram_cmd_e  cmd,
	output sdram_pkg::host_addr_t  cmd_addr,
	output logic                   precharge_all,
	output logic                   capture,
	output logic                   set_open,
	output logic                   clear_open,
	output logic                   refresh_issued,
	output logic                   init_done,
	output logic                   ack
);

	localparam int WAIT_W = 3;                        // Covers T_RFC, T_MRD and CL
	localparam int INIT_W = $clog2(INIT_DELAY + 1);

	typedef enum logic [3:0]
	{
		ST_INIT_WAIT,    // Power-up delay, NOPs
		ST_INIT_REF1,
		ST_INIT_REF2,
		ST_INIT_LMR,
		ST_IDLE,         // Row may be open or closed
		ST_ACTIVE,
		ST_READING,
		ST_WRITING,
		ST_PRECHARGING,
		ST_REFRESHING
	} state_e;

	state_e state, state_d;
	logic [WAIT_W-1:0] wait_cnt;  // Cycles spent in current state
	logic [INIT_W-1:0] init_cnt;
	logic init_done_q;
	logic ack_q, ack_d;
	logic access;                 // Command carries the request address

	////////////////////////////////////////
	// State and counters
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state       <= ST_INIT_WAIT;
			wait_cnt    <= '0;
			init_cnt    <= '0;
			init_done_q <= 1'b0;
			ack_q       <= 1'b0;
		end
		else
		begin
			state    <= state_d;
			wait_cnt <= (state_d != state) ? '0 : wait_cnt + 1'b1;  // Restart on every move
			ack_q    <= ack_d;
			if (state == ST_INIT_WAIT)
				init_cnt <= init_cnt + 1'b1;
			if (state == ST_INIT_LMR && state_d == ST_IDLE)
				init_done_q <= 1'b1;  // Device configured
		end
	end

	////////////////////////////////////////
	// Next state and command decode
	////////////////////////////////////////

	always_comb
	begin
		state_d        = state;
		cmd            = sdram_pkg::CMD_NOP;  // NOP unless chosen below
		precharge_all  = 1'b0;
		capture        = 1'b0;
		set_open       = 1'b0;
		clear_open     = 1'b0;
		refresh_issued = 1'b0;
		ack_d          = 1'b0;
		access         = 1'b0;
		case (state)
			ST_INIT_WAIT:
			begin
				if (init_cnt == INIT_W'(INIT_DELAY - 1))
				begin
					cmd           = sdram_pkg::CMD_PRECHARGE;
					precharge_all = 1'b1;
					state_d       = ST_INIT_REF1;
				end
			end
			ST_INIT_REF1, ST_INIT_REF2:
			begin
				if (wait_cnt == '0)
					cmd = sdram_pkg::CMD_REFRESH;  // Then T_RFC NOPs
				if (wait_cnt == WAIT_W'(sdram_pkg::T_RFC))
					state_d = (state == ST_INIT_REF1) ? ST_INIT_REF2 : ST_INIT_LMR;
			end
			ST_INIT_LMR:
			begin
				if (wait_cnt == '0)
					cmd = sdram_pkg::CMD_LMR;
				if (wait_cnt == WAIT_W'(sdram_pkg::T_MRD))
					state_d = ST_IDLE;
			end
			ST_IDLE:
			begin
				// Refresh first, closing any open row
				if (refresh_pending)
				begin
					if (row_open)
					begin
						cmd           = sdram_pkg::CMD_PRECHARGE;
						precharge_all = 1'b1;
						clear_open    = 1'b1;
						state_d       = ST_PRECHARGING;
					end
					else
					begin
						cmd            = sdram_pkg::CMD_REFRESH;
						refresh_issued = 1'b1;
						state_d        = ST_REFRESHING;
					end
				end
				else if (pending && !ack_q)  // Request not yet answered
				begin
					if (row_hit)
					begin
						access  = 1'b1;
						cmd     = req_q.write ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
						state_d = req_q.write ? ST_WRITING : ST_READING;
					end
					else if (row_open)  // Wrong row, close it
					begin
						cmd           = sdram_pkg::CMD_PRECHARGE;
						precharge_all = 1'b1;
						clear_open    = 1'b1;
						state_d       = ST_PRECHARGING;
					end
					else
					begin
						access   = 1'b1;
						cmd      = sdram_pkg::CMD_ACTIVE;
						set_open = 1'b1;
						state_d  = ST_ACTIVE;
					end
				end
			end
			ST_ACTIVE:
				if (wait_cnt == WAIT_W'(sdram_pkg::T_RCD - 1))
					state_d = ST_IDLE;
			ST_PRECHARGING:
				if (wait_cnt == WAIT_W'(sdram_pkg::T_RP - 1))
					state_d = ST_IDLE;
			ST_REFRESHING:
				if (wait_cnt == WAIT_W'(sdram_pkg::T_RFC - 1))
					state_d = ST_IDLE;
			ST_READING:
			begin
				// Data sampled here, ack and rd_data next cycle
				if (wait_cnt == WAIT_W'(sdram_pkg::CAS_LATENCY - 1))
				begin
					capture = 1'b1;
					ack_d   = 1'b1;
					state_d = ST_IDLE;
				end
			end
			ST_WRITING:
			begin
				ack_d   = 1'b1;  // Write data went out with the command
				state_d = ST_IDLE;
			end
			default:
				state_d = ST_IDLE;
		endcase
	end

	assign cmd_addr  = access ? req_q.addr : '0;
	assign init_done = init_done_q;
	assign ack       = ack_q;

endmodule

// ==== src/sdram_ctrl_top.sv ====
`timescale 1ns/1ps

module sdram_ctrl_top #(
	parameter int INIT_DELAY     = 3200,  // Power-up wait in clocks
	parameter int REFRESH_PERIOD = 490    // Just under 15.6 us
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          req,
	input  sdram_pkg::host_req_t          host_req,
	output logic                          ack,
	output logic [sdram_pkg::DATA_W-1:0]  rd_data,
	output sdram_pkg::sdram_pins_t        pins,
	output logic [sdram_pkg::DATA_W-1:0]  dq_out,
	output logic                          dq_oe,
	input  logic [sdram_pkg::DATA_W-1:0]  dq_in
);

	// Request latch to fsm
	logic pending, row_hit, row_open;
	sdram_pkg::host_req_t req_q;
	logic set_open, clear_open;

	// Refresh handshake
	logic refresh_pending, refresh_issued, init_done;

	// Fsm to pin driver
	sdram_pkg::sdram_cmd_e cmd;
	sdram_pkg::host_addr_t cmd_addr;
	logic precharge_all, capture;

	sdram_ctrl_fsm #(.INIT_DELAY(INIT_DELAY)) u_fsm (
		.clk(clk), .rst(rst),
		.pending(pending), .row_hit(row_hit), .row_open(row_open), .req_q(req_q),
		.refresh_pending(refresh_pending),
		.cmd(cmd), .cmd_addr(cmd_addr), .precharge_all(precharge_all), .capture(capture),
		.set_open(set_open), .clear_open(clear_open), .refresh_issued(refresh_issued),
		.init_done(init_done), .ack(ack)
	);

	sdram_req_latch u_req_latch (
		.clk(clk), .rst(rst),
		.req(req), .host_req(host_req),
		.set_open(set_open), .clear_open(clear_open), .ack(ack),
		.pending(pending), .req_q(req_q), .row_hit(row_hit), .row_open(row_open)
	);

	sdram_refresh_timer #(.REFRESH_PERIOD(REFRESH_PERIOD)) u_refresh_timer (
		.clk(clk), .rst(rst),
		.init_done(init_done), .refresh_issued(refresh_issued),
		.refresh_pending(refresh_pending)
	);

	sdram_pin_driver u_pin_driver (
		.clk(clk), .rst(rst), .init_done(init_done),
		.cmd(cmd), .cmd_addr(cmd_addr), .precharge_all(precharge_all),
		.wdata(req_q.wdata), .capture(capture),
		.pins(pins), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in), .rd_data(rd_data)
	);

endmodule

// ==== verification/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model (
	input  logic                          clk,
	input  sdram_pkg::sdram_pins_t        pins,
	input  logic [sdram_pkg::DATA_W-1:0]  dq_out,
	input  logic                          dq_oe,
	output logic [sdram_pkg::DATA_W-1:0]  dq_in,
	output sdram_pkg::sdram_cmd_e         cmd,
	output int                            errors
);

	localparam int BANKS = 1 << sdram_pkg::BANK_W;

	logic [sdram_pkg::DATA_W-1:0] mem [int];                          // Sparse storage
	logic [sdram_pkg::DATA_W-1:0] rd_pipe [sdram_pkg::CAS_LATENCY-1];
	logic [BANKS-1:0]             bank_open = '0;
	logic [sdram_pkg::ROW_W-1:0]  open_row [BANKS];
	int since_ref = sdram_pkg::T_RFC + 1;                             // Cycles since last REFRESH
	int err_total = 0;
	int n_err;
	int addr;

	// Deselect decodes as NOP
	always_comb
	begin
		cmd = sdram_pkg::CMD_NOP;
		if (pins.cke && !pins.cs_n)
			case ({pins.ras_n, pins.cas_n, pins.we_n})
				3'b011:  cmd = sdram_pkg::CMD_ACTIVE;
				3'b101:  cmd = sdram_pkg::CMD_READ;
				3'b100:  cmd = sdram_pkg::CMD_WRITE;
				3'b010:  cmd = sdram_pkg::CMD_PRECHARGE;
				3'b001:  cmd = sdram_pkg::CMD_REFRESH;
				3'b000:  cmd = sdram_pkg::CMD_LMR;
				default: cmd = sdram_pkg::CMD_NOP;
			endcase
	end

	////////////////////////////////////////
	// Command execution and legality
	////////////////////////////////////////

	always @(posedge clk)
	begin
		n_err = 0;
		addr  = int'({pins.ba, open_row[pins.ba], pins.a[sdram_pkg::COL_W-1:0]});
		if (since_ref <= sdram_pkg::T_RFC)
			since_ref <= since_ref + 1;
		if (cmd != sdram_pkg::CMD_NOP && since_ref <= sdram_pkg::T_RFC)
		begin
			$display("%s issued only %0d cycles after REFRESH", cmd.name(), since_ref);
			n_err++;
		end
		case (cmd)
			sdram_pkg::CMD_ACTIVE:
			begin
				if (bank_open[pins.ba])
				begin
					$display("ACTIVE to bank %0d which already has an open row", pins.ba);
					n_err++;
				end
				bank_open[pins.ba] <= 1'b1;
				open_row[pins.ba]  <= pins.a;
			end
			sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE:
			begin
				if (!bank_open[pins.ba])
				begin
					$display("%s to bank %0d with no open row", cmd.name(), pins.ba);
					n_err++;
				end
				else if (cmd == sdram_pkg::CMD_WRITE && !dq_oe)
				begin
					$display("WRITE to bank %0d without data driven on dq", pins.ba);
					n_err++;
				end
				else if (cmd == sdram_pkg::CMD_WRITE)
					mem[addr] = dq_out;
			end
			sdram_pkg::CMD_PRECHARGE:
				if (pins.a[sdram_pkg::A10_BIT])
					bank_open <= '0;              // All banks
				else
					bank_open[pins.ba] <= 1'b0;
			sdram_pkg::CMD_REFRESH:
			begin
				if (|bank_open)
				begin
					$display("REFRESH while a row is still open");
					n_err++;
				end
				since_ref <= 1;
			end
			sdram_pkg::CMD_LMR:
				if (|bank_open)
				begin
					$display("Mode register load while a row is still open");
					n_err++;
				end
			default:
				;  // NOP is always legal
		endcase
		// Pins arrive one edge after the controller set them, so data leaves CL-1 edges later
		rd_pipe[0] <= (cmd == sdram_pkg::CMD_READ && bank_open[pins.ba] && mem.exists(addr))
			? mem[addr] : '0;
		for (int i = 1; i < sdram_pkg::CAS_LATENCY - 1; i++)
			rd_pipe[i] <= rd_pipe[i-1];
		err_total <= err_total + n_err;
	end

	assign dq_in  = rd_pipe[sdram_pkg::CAS_LATENCY-2];
	assign errors = err_total;

endmodule

// ==== verification/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps

module tb_sdram_ctrl;

	localparam int INIT_DELAY     = 20;
	localparam int REFRESH_PERIOD = 60;
	localparam int MAX_REQ        = 64;

	logic clk = 1'b0;
	logic rst;
	logic req;
	sdram_pkg::host_req_t host_req;
	logic ack;
	logic dq_oe;
	logic [sdram_pkg::DATA_W-1:0] rd_data, dq_out, dq_in;
	sdram_pkg::sdram_pins_t pins;
	sdram_pkg::sdram_cmd_e seen_cmd;  // Decoded by the model
	int model_errors;

	// Trace contents
	logic [7:0]                   op_q   [MAX_REQ];
	logic [sdram_pkg::ADDR_W-1:0] addr_q [MAX_REQ];
	logic [sdram_pkg::DATA_W-1:0] data_q [MAX_REQ];
	string                        name_q [MAX_REQ];
	int n_req = 0;
	bit loaded = 1'b0;

	int errors = 0, init_errors = 0, gap_errors = 0;
	int tests = 0, failed_tests = 0;
	int ack_cnt = 0;
	int cyc, init_idx, last_ref;      // Bus monitor state

	always #2 clk = ~clk;

	sdram_ctrl_top #(.INIT_DELAY(INIT_DELAY), .REFRESH_PERIOD(REFRESH_PERIOD)) u_dut (
		.clk(clk), .rst(rst), .req(req), .host_req(host_req), .ack(ack), .rd_data(rd_data),
		.pins(pins), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
	);

	sdram_model u_model (
		.clk(clk), .pins(pins), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in),
		.cmd(seen_cmd), .errors(model_errors)
	);

	////////////////////////////////////////
	// Compare and report helpers
	////////////////////////////////////////

	task automatic check_data(input string name, input logic [sdram_pkg::DATA_W-1:0] expected,
		input logic [sdram_pkg::DATA_W-1:0] actual, inout int err_cnt);
		if (actual !== expected)
		begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic check_cmd(input string name, input sdram_pkg::sdram_cmd_e expected,
		input sdram_pkg::sdram_cmd_e actual, inout int err_cnt);
		if (actual !== expected)
		begin
			$display("Mismatch in %s: expected %s, actual %s", name, expected.name(), actual.name());
			err_cnt++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual,
		inout int err_cnt);
		if (actual != expected)
		begin
			$display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic report_error(input string msg, inout int err_cnt);
		$display("%s", msg);
		err_cnt++;
	endtask

	task automatic report_test(input string name, input bit ok);
		tests++;
		if (!ok)
			failed_tests++;
		$display("%s: %s", name, ok ? "ok" : "failed");
	endtask

	// Power-up order after the initial delay
	function automatic sdram_pkg::sdram_cmd_e expected_init_cmd(input int idx);
		case (idx)
			0:       return sdram_pkg::CMD_PRECHARGE;
			3:       return sdram_pkg::CMD_LMR;
			default: return sdram_pkg::CMD_REFRESH;
		endcase
	endfunction

	// Mode word from A11 down to A0
	function automatic logic [sdram_pkg::ROW_W-1:0] expected_mode_word();
		return {
			2'b00,                          // Reserved
			1'b1,                           // Single location write burst
			2'b00,                          // Standard operation
			3'(sdram_pkg::CAS_LATENCY),
			1'b0,                           // Sequential
			3'b000                          // Burst length 1
		};
	endfunction

	task automatic load_trace();
		int fd;
		string line, nm;
		logic [7:0] op;
		logic [sdram_pkg::ADDR_W-1:0] addr;
		logic [sdram_pkg::DATA_W-1:0] data;
		fd = $fopen("verification/sdram_trace.txt", "r");
		if (fd == 0)
			report_error("Cannot open the trace file verification/sdram_trace.txt", errors);
		else
		begin
			while (!$feof(fd) && n_req < MAX_REQ)
			begin
				if ($fgets(line, fd) > 0 && line[0] != "#")  // Skip comment lines
					if ($sscanf(line, "%c %h %h %s", op, addr, data, nm) == 4)
					begin
						op_q[n_req]   = op;
						addr_q[n_req] = addr;
						data_q[n_req] = data;
						name_q[n_req] = nm;
						n_req++;
					end
			end
			$fclose(fd);
		end
	endtask

	// Strobe one host request and wait for its ack
	task automatic run_request(input int i);
		int err_start;
		sdram_pkg::host_req_t r;
		err_start = errors + model_errors;
		r.write   = (op_q[i] == "w");
		r.addr    = sdram_pkg::host_addr_t'(addr_q[i]);
		r.wdata   = r.write ? data_q[i] : '0;
		req      <= 1'b1;
		host_req <= r;
		@(posedge clk);
		req <= 1'b0;
		@(posedge clk);
		while (ack !== 1'b1)
			@(posedge clk);
		if (!r.write)
			check_data(name_q[i], data_q[i], rd_data, errors);  // Valid with ack
		report_test(name_q[i], errors + model_errors == err_start);
	endtask

	////////////////////////////////////////
	// Bus monitor for init order and refresh spacing
	////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst)
		begin
			cyc      <= 0;
			init_idx <= 0;
		end
		else
		begin
			cyc <= cyc + 1;
			if (ack)
				ack_cnt <= ack_cnt + 1;
			if (init_idx < 4 && seen_cmd != sdram_pkg::CMD_NOP)
			begin
				if (init_idx == 0 && cyc < INIT_DELAY)
					report_error($sformatf("First command after only %0d cycles", cyc), init_errors);
				check_cmd("init_sequence", expected_init_cmd(init_idx), seen_cmd, init_errors);
				if (seen_cmd == sdram_pkg::CMD_PRECHARGE && !pins.a[sdram_pkg::A10_BIT])
					report_error("Power-up PRECHARGE without A10 high", init_errors);
				if (seen_cmd == sdram_pkg::CMD_LMR)
					check_data("mode_register", {4'h0, expected_mode_word()}, {4'h0, pins.a},
						init_errors);
				if (init_idx == 3)
					report_test("init_sequence", init_errors == 0);
				init_idx <= init_idx + 1;
				last_ref <= cyc;  // Refresh interval starts at mode load
			end
			else if (init_idx == 4)
			begin
				if (cyc - last_ref == REFRESH_PERIOD + 13)  // Reported once per gap
					report_error($sformatf("No REFRESH in the %0d cycles after cycle %0d",
						REFRESH_PERIOD + 12, last_ref), gap_errors);
				if (seen_cmd == sdram_pkg::CMD_REFRESH)
					last_ref <= cyc;
			end
		end
	end

	// Limit scales with the trace length
	initial
	begin
		wait (loaded);
		repeat (n_req * 40 + INIT_DELAY + 200)
			@(posedge clk);
		$display("Timeout, the controller stopped answering requests");
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		rst      <= 1'b1;
		req      <= 1'b0;
		host_req <= '0;
		load_trace();
		loaded = 1'b1;
		repeat (4)
			@(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < n_req; i++)
			run_request(i);  // First one lands before init ends
		repeat (2 * REFRESH_PERIOD)
			@(posedge clk);  // Idle refreshes only
		if (init_idx < 4)
			report_error("Power-up sequence never completed", init_errors);
		check_count("ack_count", n_req, ack_cnt, errors);
		report_test("refresh_spacing", gap_errors == 0);
		$display("Tests: %0d run, %0d failed, errors %0d testbench and %0d model", tests,
			failed_tests, errors + init_errors + gap_errors, model_errors);
		if (errors + init_errors + gap_errors + model_errors == 0 && failed_tests == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== verification/sdram_trace.txt ====
# op (w or r), address hex {bank,row,col}, write data or expected read data, test name
# Reads expect the last data written there, zero if never written
w 000010 a5a5 wr_before_init
r 000010 a5a5 rd_row_hit
r 000011 0000 rd_unwritten
w 000011 1234 wr_same_row
w 001010 beef wr_row_miss
r 000011 1234 rd_back_to_row0
r 001010 beef rd_row1
w 100020 cafe wr_bank1
r 100020 cafe rd_bank1
w 3fffff 0f0f wr_top_corner
r 3fffff 0f0f rd_top_corner
w 000010 5a5a wr_overwrite
r 000010 5a5a rd_overwrite
r 2abc01 0000 rd_bank2_unwritten
w 2abc01 7e57 wr_bank2
r 2abc01 7e57 rd_bank2
r 100020 cafe rd_bank1_again
r 001010 beef rd_row1_again

// ==== flist.f ====
src/sdram_pkg.sv
src/sdram_refresh_timer.sv
src/sdram_req_latch.sv
src/sdram_pin_driver.sv
src/sdram_ctrl_fsm.sv
src/sdram_ctrl_top.sv
verification/sdram_model.sv
verification/tb_sdram_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_sdram_ctrl
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
